// File: hdl/analyzer_pkg.sv
package analyzer_pkg;

	// Counts and widths ------------
	localparam int NUM_ROUTES = 8;
	localparam int NUM_CMP    = 4;
	localparam int REC_ADR_W  = 10;
	localparam int IMG_ADR_W  = 12;
	localparam int SAMPLE_W   = 32;

	// Host address map -------------
	localparam logic [15:0] MAP_IMG  = 16'h1000;
	localparam logic [15:0] MAP_REC  = 16'h2000;
	localparam logic [15:0] ADR_ATOM = 16'hff10;
	localparam logic [15:0] ADR_ONES = 16'hff14;
	localparam logic [15:0] ADR_REC  = 16'hff15;
	localparam logic [15:0] ADR_PA   = 16'hff40;
	localparam logic [15:0] ADR_BUS  = 16'hff50;

	localparam logic [1:0] SUB_PA_SET      = 2'd0;
	localparam logic [1:0] SUB_PA_RST      = 2'd1;
	localparam logic [1:0] SUB_PA_TRIG_SET = 2'd2;
	localparam logic [1:0] SUB_PA_TRIG_RST = 2'd3;
	localparam logic [1:0] SUB_BUS_TRIG    = 2'd1;
	localparam logic [1:0] SUB_BUS_CMP     = 2'd3;

	typedef logic [NUM_ROUTES-1:0] route_t;

	// All levels are active high here, whatever the pin polarity
	typedef struct packed {
		logic        pad;
		logic        pa0;
		logic        reset;
		logic        phi;
		logic        wr;
		logic        rd;
		logic        cs_xram;
		logic        ddrv;
		logic [7:0]  data;
		logic        cs_rom;
		logic [14:0] adr;
	} bus_fields_t;

	typedef union packed {
		bus_fields_t         f;
		logic [SAMPLE_W-1:0] raw;
	} bus_sample_u;

endpackage

// File: hdl/host_cfg_if.sv
interface host_cfg_if;

	logic [7:0]                         wdata;
	logic [analyzer_pkg::SAMPLE_W-1:0]  atom;
	logic [1:0]                         sub;
	logic [analyzer_pkg::IMG_ADR_W-1:0] img_adr;

	// One-cycle write strobes, at most one per host write
	logic wr_img;
	logic wr_ones;
	logic wr_rec;
	logic wr_pa;
	logic wr_bus_trig;
	logic wr_bus_cmp;

	modport cfg_src (
		output wdata, atom, sub, img_adr,
		output wr_img, wr_ones, wr_rec, wr_pa, wr_bus_trig, wr_bus_cmp
	);

	modport cfg_dst (
		input wdata, atom, sub, img_adr,
		input wr_img, wr_ones, wr_rec, wr_pa, wr_bus_trig, wr_bus_cmp
	);

endinterface

// File: hdl/host_decoder.sv
module host_decoder (
	input  logic                              pllclk,
	input  logic                              f_reset,
	input  logic [15:0]                       host_adr,
	input  logic [7:0]                        host_wdata,
	input  logic                              host_wr,
	input  logic                              host_rd,
	host_cfg_if.cfg_src                       cfg,
	input  logic [7:0]                        img_rdata,
	input  logic [analyzer_pkg::SAMPLE_W-1:0] rec_rdata,
	input  analyzer_pkg::bus_sample_u         sample,
	input  logic [7:0]                        pa_out,
	input  logic [7:0]                        pa_in,
	output logic [7:0]                        host_rdata
);

	logic [1:0]                        sub;
	logic                              sel_img, sel_rec, sel_atom, sel_ones;
	logic                              sel_recctl, sel_pa, sel_bus;
	logic [analyzer_pkg::SAMPLE_W-1:0] atom;
	logic [7:0]                        reg_byte;
	logic [7:0]                        live_byte;
	logic                              rd_pend_q, rd_img_q, rd_rec_q;
	logic [1:0]                        rd_sub_q;
	logic [7:0]                        rd_byte_q;
	logic [7:0]                        hold_q;

	assign sub = host_adr[1:0];

	// Address decode ---------------
	always_comb begin
		sel_img    = host_adr[15:12] == analyzer_pkg::MAP_IMG[15:12];
		sel_rec    = host_adr[15:12] == analyzer_pkg::MAP_REC[15:12];
		sel_atom   = host_adr[15:2] == analyzer_pkg::ADR_ATOM[15:2];
		sel_ones   = host_adr == analyzer_pkg::ADR_ONES;
		sel_recctl = host_adr == analyzer_pkg::ADR_REC;
		sel_pa     = host_adr[15:2] == analyzer_pkg::ADR_PA[15:2];
		sel_bus    = host_adr[15:2] == analyzer_pkg::ADR_BUS[15:2];
	end

	// Wide values are assembled here bytewise before a single load strobe
	always_ff @(posedge pllclk) begin
		if (host_wr && sel_atom)
			atom[{sub, 3'b000} +: 8] <= host_wdata;
	end

	assign cfg.wdata   = host_wdata;
	assign cfg.atom    = atom;
	assign cfg.sub     = sub;
	assign cfg.img_adr = host_adr[analyzer_pkg::IMG_ADR_W-1:0];

	assign cfg.wr_img      = host_wr && sel_img;
	assign cfg.wr_ones     = host_wr && sel_ones;
	assign cfg.wr_rec      = host_wr && sel_recctl;
	assign cfg.wr_bus_trig = host_wr && sel_bus && sub == analyzer_pkg::SUB_BUS_TRIG;
	assign cfg.wr_bus_cmp  = host_wr && sel_bus && sub == analyzer_pkg::SUB_BUS_CMP;

	// Route mask loads on Port A only happen with data bit 0 set
	assign cfg.wr_pa = host_wr && sel_pa &&
		(sub == analyzer_pkg::SUB_PA_SET || sub == analyzer_pkg::SUB_PA_RST || host_wdata[0]);

	// Read path --------------------
	always_comb begin
		reg_byte = 8'hff;
		if (sel_atom)
			reg_byte = atom[{sub, 3'b000} +: 8];
		else if (sel_pa && sub == analyzer_pkg::SUB_PA_SET)
			reg_byte = pa_out;
		else if (sel_pa && sub == analyzer_pkg::SUB_PA_RST)
			reg_byte = pa_in;
		else if (sel_bus)
			reg_byte = sample.raw[{sub, 3'b000} +: 8];
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			rd_pend_q <= 1'b0;
			rd_img_q  <= 1'b0;
			rd_rec_q  <= 1'b0;
			rd_sub_q  <= 2'd0;
			rd_byte_q <= 8'hff;
		end else begin
			rd_pend_q <= host_rd;
			if (host_rd) begin
				rd_img_q  <= sel_img;
				rd_rec_q  <= sel_rec;
				rd_sub_q  <= sub;
				rd_byte_q <= reg_byte;
			end
		end
	end

	// RAM bytes arrive registered by their own blocks in the cycle after the read
	always_comb begin
		live_byte = rd_byte_q;
		if (rd_img_q)
			live_byte = img_rdata;
		else if (rd_rec_q)
			live_byte = rec_rdata[{rd_sub_q, 3'b000} +: 8];
	end

	always_ff @(posedge pllclk) begin
		if (f_reset)
			hold_q <= 8'hff;
		else
			hold_q <= host_rdata;
	end

	assign host_rdata = rd_pend_q ? live_byte : hold_q;

endmodule

// File: hdl/bus_frontend.sv
module bus_frontend (
	input  logic                      pllclk,
	input  logic                      f_reset,
	host_cfg_if.cfg_dst               cfg,
	input  logic [14:0]               dut_adr,
	input  logic [7:0]                dut_din,
	input  logic                      n_rd,
	input  logic                      n_wr,
	input  logic                      n_cs_rom,
	input  logic                      n_cs_xram,
	input  logic                      phi,
	input  logic                      n_reset,
	input  logic [7:0]                pa_in,
	output logic [7:0]                dut_dout,
	output logic                      dut_doe,
	output logic                      n_soe,
	output logic                      sdir,
	output analyzer_pkg::bus_sample_u sample,
	output logic [7:0]                pa_in_q,
	output logic [7:0]                img_rdata
);

	localparam int IMG_DEPTH = 1 << analyzer_pkg::IMG_ADR_W;

	logic [14:0] adr_q;
	logic [7:0]  din_q;
	logic        rd_q, wr_q, cs_rom_q, cs_xram_q, phi_q, reset_q;
	logic        any_cs, lvl_ena, sdir_n, doe_n;
	logic [7:0]  rom_img [0:IMG_DEPTH-1];
	logic [7:0]  cap_ram [0:IMG_DEPTH-1];

	// Pin sampling -----------------
	always_ff @(posedge pllclk) begin
		adr_q     <= dut_adr;
		din_q     <= dut_din;
		phi_q     <= phi;
		reset_q   <= !n_reset;
		pa_in_q   <= pa_in;
		rd_q      <= !n_rd;
		wr_q      <= !n_wr;
		cs_rom_q  <= !n_cs_rom;
		cs_xram_q <= !n_cs_xram;

		if (f_reset) begin
			rd_q      <= 1'b0;
			wr_q      <= 1'b0;
			cs_rom_q  <= 1'b0;
			cs_xram_q <= 1'b0;
		end
	end

	always_comb begin
		sample.f.pad     = 1'b0;
		sample.f.pa0     = pa_in_q[0];
		sample.f.reset   = reset_q;
		sample.f.phi     = phi_q;
		sample.f.wr      = wr_q;
		sample.f.rd      = rd_q;
		sample.f.cs_xram = cs_xram_q;
		sample.f.ddrv    = dut_doe;
		sample.f.data    = din_q;
		sample.f.cs_rom  = cs_rom_q;
		sample.f.adr     = adr_q;
	end

	// On a read the level shifter turns first, and the driver follows a cycle later
	always_comb begin
		any_cs  = cs_rom_q || (cs_xram_q && adr_q[13] && !adr_q[14]);
		lvl_ena = any_cs;
		sdir_n  = sdir;
		doe_n   = dut_doe;

		if (rd_q && any_cs) begin
			sdir_n = 1'b1;
			if (sdir)
				doe_n = 1'b1;
		end else begin
			doe_n = 1'b0;
			if (!dut_doe)
				sdir_n = 1'b0;
			else
				lvl_ena = 1'b0;
		end
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			sdir    <= 1'b0;
			dut_doe <= 1'b0;
			n_soe   <= 1'b1;
		end else begin
			sdir    <= sdir_n;
			dut_doe <= doe_n;
			n_soe   <= !lvl_ena;
		end
	end

	// ROM image and write capture --
	always_ff @(posedge pllclk) begin
		dut_dout  <= rom_img[adr_q[11:0]];
		img_rdata <= cap_ram[cfg.img_adr];

		if (cfg.wr_img)
			rom_img[cfg.img_adr] <= cfg.wdata;
		if (wr_q && cs_xram_q && adr_q[13])
			cap_ram[adr_q[11:0]] <= din_q;
	end

endmodule

// File: hdl/trigger_matrix.sv
module trigger_matrix (
	input  logic                      pllclk,
	input  logic                      f_reset,
	host_cfg_if.cfg_dst               cfg,
	input  analyzer_pkg::bus_sample_u sample,
	output analyzer_pkg::route_t      route
);

	localparam int NUM_CMP = analyzer_pkg::NUM_CMP;

	logic [analyzer_pkg::SAMPLE_W-1:0] cmp_val  [NUM_CMP];
	logic [analyzer_pkg::SAMPLE_W-1:0] cmp_mask [NUM_CMP];
	analyzer_pkg::route_t              lvl_mask [NUM_CMP];
	analyzer_pkg::route_t              edge_mask[NUM_CMP];
	analyzer_pkg::route_t              ones_mask;
	analyzer_pkg::route_t              route_next;
	logic [NUM_CMP-1:0]                match, match_q;

	// Comparison values are loaded from atom by the low data bits
	always_ff @(posedge pllclk) begin
		for (int i = 0; i < NUM_CMP; i++) begin
			if (cfg.wr_bus_cmp && cfg.wdata[i])
				cmp_val[i] <= cfg.atom;
		end
	end

	// Mask registers ---------------
	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			ones_mask <= '0;
			for (int i = 0; i < NUM_CMP; i++) begin
				cmp_mask[i]  <= '0;
				lvl_mask[i]  <= '0;
				edge_mask[i] <= '0;
			end
		end else begin
			if (cfg.wr_ones)
				ones_mask <= cfg.atom[analyzer_pkg::NUM_ROUTES-1:0];
			for (int i = 0; i < NUM_CMP; i++) begin
				if (cfg.wr_bus_cmp && cfg.wdata[i + NUM_CMP])
					cmp_mask[i] <= cfg.atom;
				if (cfg.wr_bus_trig && cfg.wdata[i])
					lvl_mask[i] <= cfg.atom[analyzer_pkg::NUM_ROUTES-1:0];
				if (cfg.wr_bus_trig && cfg.wdata[i + NUM_CMP])
					edge_mask[i] <= cfg.atom[analyzer_pkg::NUM_ROUTES-1:0];
			end
		end
	end

	always_comb begin
		route_next = ones_mask;
		for (int i = 0; i < NUM_CMP; i++) begin
			match[i] = ((sample.raw ^ cmp_val[i]) & cmp_mask[i]) == '0;
			if (match[i]) begin
				route_next = route_next | lvl_mask[i];
				// Edge routes fire only on the first matching sample
				if (!match_q[i])
					route_next = route_next | edge_mask[i];
			end
		end
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			route   <= '0;
			match_q <= '0;
		end else begin
			route   <= route_next;
			match_q <= match;
		end
	end

endmodule

// File: hdl/port_a_ctrl.sv
module port_a_ctrl (
	input  logic                 pllclk,
	input  logic                 f_reset,
	host_cfg_if.cfg_dst          cfg,
	input  analyzer_pkg::route_t route,
	output logic [7:0]           pa_out
);

	analyzer_pkg::route_t trig_set, trig_rst;
	logic [7:0]           set_mask, rst_mask;

	always_comb begin
		set_mask = (cfg.wr_pa && cfg.sub == analyzer_pkg::SUB_PA_SET) ? cfg.wdata : 8'h00;
		rst_mask = (cfg.wr_pa && cfg.sub == analyzer_pkg::SUB_PA_RST) ? cfg.wdata : 8'h00;

		// Only bit 0 follows the routes
		set_mask[0] = set_mask[0] || |(trig_set & route);
		rst_mask[0] = rst_mask[0] || |(trig_rst & route);
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			pa_out   <= 8'h00;
			trig_set <= '0;
			trig_rst <= '0;
		end else begin
			pa_out <= (pa_out | set_mask) & ~rst_mask;
			if (cfg.wr_pa && cfg.sub == analyzer_pkg::SUB_PA_TRIG_SET)
				trig_set <= cfg.atom[analyzer_pkg::NUM_ROUTES-1:0];
			if (cfg.wr_pa && cfg.sub == analyzer_pkg::SUB_PA_TRIG_RST)
				trig_rst <= cfg.atom[analyzer_pkg::NUM_ROUTES-1:0];
		end
	end

endmodule

// File: hdl/bus_recorder.sv
module bus_recorder (
	input  logic                              pllclk,
	input  logic                              f_reset,
	host_cfg_if.cfg_dst                       cfg,
	input  analyzer_pkg::bus_sample_u         sample,
	input  analyzer_pkg::route_t              route,
	output logic [analyzer_pkg::SAMPLE_W-1:0] rec_rdata
);

	localparam int REC_DEPTH = 1 << analyzer_pkg::REC_ADR_W;

	logic [analyzer_pkg::REC_ADR_W-1:0] rec_adr;
	analyzer_pkg::route_t               cap_mask;
	logic                               capture;
	logic [analyzer_pkg::SAMPLE_W-1:0]  sample_q;
	logic [analyzer_pkg::SAMPLE_W-1:0]  rec_ram [0:REC_DEPTH-1];

	assign capture = |(cap_mask & route);

	// The address wraps at the end of the RAM
	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			rec_adr  <= '0;
			cap_mask <= '0;
		end else begin
			if (capture)
				rec_adr <= rec_adr + 1'b1;

			// A host load wins over a capture in the same cycle
			if (cfg.wr_rec && cfg.wdata[0])
				rec_adr <= cfg.atom[analyzer_pkg::REC_ADR_W-1:0];
			if (cfg.wr_rec && cfg.wdata[1])
				cap_mask <= cfg.atom[analyzer_pkg::NUM_ROUTES-1:0];
		end
	end

	// Recording RAM ----------------
	always_ff @(posedge pllclk) begin
		// The route lags its sample by one cycle, so the older sample is stored
		sample_q <= sample.raw;
		if (capture)
			rec_ram[rec_adr] <= sample_q;

		rec_rdata <= rec_ram[cfg.img_adr[analyzer_pkg::IMG_ADR_W-1:2]];
	end

endmodule

// File: hdl/bus_analyzer_top.sv
module bus_analyzer_top (
	input  logic        pllclk,
	input  logic        f_reset,

	input  logic [15:0] host_adr,
	input  logic [7:0]  host_wdata,
	input  logic        host_wr,
	input  logic        host_rd,
	output logic [7:0]  host_rdata,

	input  logic [14:0] dut_adr,
	input  logic [7:0]  dut_din,
	input  logic        n_rd,
	input  logic        n_wr,
	input  logic        n_cs_rom,
	input  logic        n_cs_xram,
	input  logic        phi,
	input  logic        n_reset,
	output logic [7:0]  dut_dout,
	output logic        dut_doe,
	output logic        n_soe,
	output logic        sdir,

	input  logic [7:0]  pa_in,
	output logic [7:0]  pa_out
);

	analyzer_pkg::bus_sample_u         sample;
	analyzer_pkg::route_t              route;
	logic [7:0]                        img_rdata;
	logic [7:0]                        pa_in_q;
	logic [analyzer_pkg::SAMPLE_W-1:0] rec_rdata;

	host_cfg_if cfg_bus ();

	host_decoder u_host_decoder (
		.pllclk     (pllclk),
		.f_reset    (f_reset),
		.host_adr   (host_adr),
		.host_wdata (host_wdata),
		.host_wr    (host_wr),
		.host_rd    (host_rd),
		.cfg        (cfg_bus.cfg_src),
		.img_rdata  (img_rdata),
		.rec_rdata  (rec_rdata),
		.sample     (sample),
		.pa_out     (pa_out),
		.pa_in      (pa_in_q),
		.host_rdata (host_rdata)
	);

	bus_frontend u_bus_frontend (
		.pllclk    (pllclk),
		.f_reset   (f_reset),
		.cfg       (cfg_bus.cfg_dst),
		.dut_adr   (dut_adr),
		.dut_din   (dut_din),
		.n_rd      (n_rd),
		.n_wr      (n_wr),
		.n_cs_rom  (n_cs_rom),
		.n_cs_xram (n_cs_xram),
		.phi       (phi),
		.n_reset   (n_reset),
		.pa_in     (pa_in),
		.dut_dout  (dut_dout),
		.dut_doe   (dut_doe),
		.n_soe     (n_soe),
		.sdir      (sdir),
		.sample    (sample),
		.pa_in_q   (pa_in_q),
		.img_rdata (img_rdata)
	);

	trigger_matrix u_trigger_matrix (
		.pllclk  (pllclk),
		.f_reset (f_reset),
		.cfg     (cfg_bus.cfg_dst),
		.sample  (sample),
		.route   (route)
	);

	port_a_ctrl u_port_a_ctrl (
		.pllclk  (pllclk),
		.f_reset (f_reset),
		.cfg     (cfg_bus.cfg_dst),
		.route   (route),
		.pa_out  (pa_out)
	);

	bus_recorder u_bus_recorder (
		.pllclk    (pllclk),
		.f_reset   (f_reset),
		.cfg       (cfg_bus.cfg_dst),
		.sample    (sample),
		.route     (route),
		.rec_rdata (rec_rdata)
	);

endmodule

// File: verification/tb_checker.sv
module tb_checker (
	input  logic        pllclk,
	input  logic        chk_req,
	input  logic [1:0]  chk_sel,
	input  logic [31:0] chk_exp,
	input  int          test_id,
	input  logic        test_done,
	input  logic        run_done,
	input  logic [7:0]  host_rdata,
	input  logic [7:0]  pa_out,
	input  logic [7:0]  dut_dout,
	input  logic        dut_doe,
	input  logic        n_soe,
	input  logic        sdir,
	output int          errors
);

	int          err_count = 0;
	int          checks = 0;
	int          test_errors = 0;
	int          tests_run = 0;
	logic [31:0] actual;

	assign errors = err_count;

	function automatic string test_name(input int id);
		case (id)
			0: return "atom_readback";
			1: return "rom_emulation";
			2: return "port_a_host";
			3: return "level_trigger";
			4: return "edge_recording";
			default: return "unknown";
		endcase
	endfunction

	// Which DUT output a check looks at
	always_comb begin
		case (chk_sel)
			2'd0: actual = {24'd0, host_rdata};
			2'd1: actual = {24'd0, pa_out};
			default: actual = {21'd0, n_soe, dut_doe, sdir, dut_dout};
		endcase
	end

	// Compare ----------------------
	always @(negedge pllclk) begin
		if (chk_req) begin
			checks = checks + 1;
			if (actual !== chk_exp) begin
				err_count = err_count + 1;
				test_errors = test_errors + 1;
				$display("FAILED %s: expected %h, actual %h", test_name(test_id),
					chk_exp, actual);
			end
		end
		if (test_done) begin
			tests_run = tests_run + 1;
			if (test_errors == 0)
				$display("Test %0d %s: ok", test_id, test_name(test_id));
			else
				$display("Test %0d %s: %0d errors", test_id, test_name(test_id),
					test_errors);
			test_errors = 0;
		end
		if (run_done)
			$display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks,
				err_count);
	end

endmodule

// File: verification/tb_top.sv
module tb_top;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYC  = 5;
	localparam int REC_STEPS  = 40;
	// Cycle budget of the five tests in order
	localparam int TEST_CYC   = 150 + 300 + 100 + 150 + 700;
	localparam int MARGIN_CYC = 400;

	logic        pllclk = 1'b0;
	logic        f_reset = 1'b1;
	logic [15:0] host_adr = '0;
	logic [7:0]  host_wdata = '0;
	logic        host_wr = 1'b0;
	logic        host_rd = 1'b0;
	logic [7:0]  host_rdata;
	logic [14:0] dut_adr = '0;
	logic [7:0]  dut_din = '0;
	logic        n_rd = 1'b1;
	logic        n_wr = 1'b1;
	logic        n_cs_rom = 1'b1;
	logic        n_cs_xram = 1'b1;
	logic        phi = 1'b0;
	logic        n_reset = 1'b1;
	logic [7:0]  dut_dout;
	logic        dut_doe;
	logic        n_soe;
	logic        sdir;
	logic [7:0]  pa_in = '0;
	logic [7:0]  pa_out;

	logic        chk_req = 1'b0;
	logic [1:0]  chk_sel = '0;
	logic [31:0] chk_exp = '0;
	int          test_id = 0;
	logic        test_done = 1'b0;
	logic        run_done = 1'b0;
	int          errors;
	integer      seed = 32'h7824_b796;

	// Model of the comparator setup
	logic [31:0] m_val[4] = '{default: '0};
	logic [31:0] m_mask[4] = '{default: '0};
	logic [7:0]  m_lvl[4] = '{default: '0};
	logic [7:0]  m_edge[4] = '{default: '0};
	logic [7:0]  m_ones = '0;

	always #(CLK_PERIOD / 2) pllclk = !pllclk;

	bus_analyzer_top UUT (.*);

	tb_checker u_checker (.*);

	// Reference functions ----------
	function automatic logic [31:0] expected_sample(input logic [14:0] adr,
		input logic [7:0] din, input logic rd_n, input logic wr_n,
		input logic cs_rom_n, input logic cs_xram_n);
		return {1'b0, pa_in[0], !n_reset, phi, !wr_n, !rd_n, !cs_xram_n, 1'b0,
			din, !cs_rom_n, adr};
	endfunction

	function automatic logic [7:0] calc_route(input logic [31:0] raw,
		input logic [31:0] prev);
		logic [7:0] r;
		r = m_ones;
		for (int i = 0; i < 4; i++) begin
			if (((raw ^ m_val[i]) & m_mask[i]) == 32'd0) begin
				r = r | m_lvl[i];
				if (((prev ^ m_val[i]) & m_mask[i]) != 32'd0)
					r = r | m_edge[i];
			end
		end
		return r;
	endfunction

	// Host bus tasks ---------------
	task automatic host_write(input logic [15:0] adr, input logic [7:0] data);
		@(posedge pllclk);
		host_adr   <= adr;
		host_wdata <= data;
		host_wr    <= 1'b1;
		@(posedge pllclk);
		host_wr <= 1'b0;
	endtask

	task automatic atom_write(input logic [31:0] value);
		for (int b = 0; b < 4; b++)
			host_write(analyzer_pkg::ADR_ATOM | 16'(b), value[8*b +: 8]);
	endtask

	task automatic check_value(input logic [1:0] sel, input logic [31:0] exp);
		@(posedge pllclk);
		chk_req <= 1'b1;
		chk_sel <= sel;
		chk_exp <= exp;
		@(posedge pllclk);
		chk_req <= 1'b0;
	endtask

	task automatic host_read(input logic [15:0] adr, input logic [7:0] exp);
		@(posedge pllclk);
		host_adr <= adr;
		host_rd  <= 1'b1;
		@(posedge pllclk);
		host_rd <= 1'b0;
		chk_req <= 1'b1;
		chk_sel <= 2'd0;
		chk_exp <= {24'd0, exp};
		@(posedge pllclk);
		chk_req <= 1'b0;
	endtask

	task automatic end_test();
		@(posedge pllclk);
		test_done <= 1'b1;
		@(posedge pllclk);
		test_done <= 1'b0;
		test_id   <= test_id + 1;
	endtask

	initial begin
		logic [31:0] value;
		logic [11:0] img_adr;
		logic [7:0]  img_byte;
		logic [7:0]  d;
		logic [7:0]  pa_model;
		logic [7:0]  r;
		logic [7:0]  lvl_data[2];
		logic [31:0] stim[REC_STEPS + 2];
		logic [31:0] exp_words[$];
		logic [14:0] adr;

		repeat (RESET_CYC) @(posedge pllclk);
		f_reset <= 1'b0;

		// Atom readback ----------------
		for (int n = 0; n < 4; n++) begin
			value = $random(seed);
			atom_write(value);
			for (int b = 0; b < 4; b++)
				host_read(analyzer_pkg::ADR_ATOM | 16'(b), value[8*b +: 8]);
		end
		end_test();

		// ROM emulation and write capture
		for (int n = 0; n < 8; n++) begin
			img_adr  = 12'($random(seed));
			img_byte = 8'($random(seed));
			host_write(analyzer_pkg::MAP_IMG | 16'(img_adr), img_byte);
			@(posedge pllclk);
			dut_adr  <= {3'b000, img_adr};
			n_cs_rom <= 1'b0;
			n_rd     <= 1'b0;
			for (int w = 0; w < 10 && !dut_doe; w++)
				@(negedge pllclk);
			// Level shifter enabled (n_soe low), direction and driver on
			check_value(2'd2, {21'd0, 1'b0, 1'b1, 1'b1, img_byte});
			@(posedge pllclk);
			n_cs_rom <= 1'b1;
			n_rd     <= 1'b1;
			img_byte = 8'($random(seed));
			@(posedge pllclk);
			dut_adr   <= {3'b010, img_adr};
			dut_din   <= img_byte;
			n_cs_xram <= 1'b0;
			n_wr      <= 1'b0;
			@(posedge pllclk);
			n_cs_xram <= 1'b1;
			n_wr      <= 1'b1;
			repeat (2) @(posedge pllclk);
			host_read(analyzer_pkg::MAP_IMG | 16'(img_adr), img_byte);
		end
		end_test();

		// Port A host control ----------
		host_write(analyzer_pkg::ADR_PA | 16'(analyzer_pkg::SUB_PA_RST), 8'hff);
		pa_model = 8'h00;
		for (int n = 0; n < 12; n++) begin
			d = 8'($random(seed));
			if ($random(seed) & 1) begin
				host_write(analyzer_pkg::ADR_PA | 16'(analyzer_pkg::SUB_PA_SET), d);
				pa_model = pa_model | d;
			end else begin
				host_write(analyzer_pkg::ADR_PA | 16'(analyzer_pkg::SUB_PA_RST), d);
				pa_model = pa_model & ~d;
			end
			check_value(2'd1, {24'd0, pa_model});
		end
		end_test();

		// Level trigger ----------------
		@(posedge pllclk);
		dut_din <= 8'h00;
		host_write(analyzer_pkg::ADR_PA | 16'(analyzer_pkg::SUB_PA_RST), 8'hff);
		atom_write(32'h005a_0000);
		host_write(analyzer_pkg::ADR_BUS | 16'(analyzer_pkg::SUB_BUS_CMP), 8'h01);
		m_val[0] = 32'h005a_0000;
		atom_write(32'h00a5_0000);
		host_write(analyzer_pkg::ADR_BUS | 16'(analyzer_pkg::SUB_BUS_CMP), 8'h02);
		m_val[1] = 32'h00a5_0000;
		atom_write(32'h00ff_0000);
		host_write(analyzer_pkg::ADR_BUS | 16'(analyzer_pkg::SUB_BUS_CMP), 8'h30);
		m_mask[0] = 32'h00ff_0000;
		m_mask[1] = 32'h00ff_0000;
		atom_write(32'h1);
		host_write(analyzer_pkg::ADR_BUS | 16'(analyzer_pkg::SUB_BUS_TRIG), 8'h01);
		host_write(analyzer_pkg::ADR_PA | 16'(analyzer_pkg::SUB_PA_TRIG_SET), 8'h01);
		m_lvl[0] = 8'h01;
		atom_write(32'h2);
		host_write(analyzer_pkg::ADR_BUS | 16'(analyzer_pkg::SUB_BUS_TRIG), 8'h02);
		host_write(analyzer_pkg::ADR_PA | 16'(analyzer_pkg::SUB_PA_TRIG_RST), 8'h01);
		m_lvl[1] = 8'h02;
		pa_model = 8'h00;
		lvl_data[0] = 8'h5a;
		lvl_data[1] = 8'ha5;
		for (int n = 0; n < 2; n++) begin
			@(posedge pllclk);
			dut_din <= lvl_data[n];
			repeat (4) @(posedge pllclk);
			value = expected_sample(dut_adr, lvl_data[n], 1'b1, 1'b1, 1'b1, 1'b1);
			r = calc_route(value, value);
			// Bit 1 is the reset route and wins over the set route
			if (r[1])
				pa_model[0] = 1'b0;
			else if (r[0])
				pa_model[0] = 1'b1;
			check_value(2'd1, {24'd0, pa_model});
		end
		end_test();

		// Edge recording ---------------
		@(posedge pllclk);
		dut_din <= 8'h00;
		atom_write(32'h0001_0000);
		host_write(analyzer_pkg::ADR_BUS | 16'(analyzer_pkg::SUB_BUS_CMP), 8'h04);
		host_write(analyzer_pkg::ADR_BUS | 16'(analyzer_pkg::SUB_BUS_CMP), 8'h40);
		m_val[2]  = 32'h0001_0000;
		m_mask[2] = 32'h0001_0000;
		atom_write(32'h4);
		host_write(analyzer_pkg::ADR_BUS | 16'(analyzer_pkg::SUB_BUS_TRIG), 8'h40);
		m_edge[2] = 8'h04;
		atom_write(32'h0);
		host_write(analyzer_pkg::ADR_REC, 8'h01);
		atom_write(32'h4);
		host_write(analyzer_pkg::ADR_REC, 8'h02);
		stim[0] = expected_sample(dut_adr, 8'h00, 1'b1, 1'b1, 1'b1, 1'b1);
		for (int s = 1; s <= REC_STEPS + 1; s++) begin
			adr = 15'($random(seed));
			d   = (s == REC_STEPS + 1) ? 8'h00 : 8'($random(seed));
			@(posedge pllclk);
			dut_adr <= adr;
			dut_din <= d;
			stim[s] = expected_sample(adr, d, 1'b1, 1'b1, 1'b1, 1'b1);
		end
		repeat (4) @(posedge pllclk);
		// The recorded word is the sample that enters the match
		for (int s = 1; s <= REC_STEPS; s++) begin
			if (calc_route(stim[s], stim[s-1]) & 8'h04)
				exp_words.push_back(stim[s]);
		end
		foreach (exp_words[j]) begin
			for (int b = 0; b < 4; b++)
				host_read(analyzer_pkg::MAP_REC | 16'(4*j + b), exp_words[j][8*b +: 8]);
		end
		end_test();

		@(posedge pllclk);
		run_done <= 1'b1;
		@(posedge pllclk);
		run_done <= 1'b0;
		@(posedge pllclk);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Watchdog ---------------------
	initial begin
		#((RESET_CYC + TEST_CYC + MARGIN_CYC) * CLK_PERIOD);
		$display("Watchdog timeout, the run did not finish in time");
		$display("tests failed");
		$finish;
	end

endmodule

// File: compile.f
hdl/analyzer_pkg.sv
hdl/host_cfg_if.sv
hdl/host_decoder.sv
hdl/bus_frontend.sv
hdl/trigger_matrix.sv
hdl/port_a_ctrl.sv
hdl/bus_recorder.sv
hdl/bus_analyzer_top.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: Makefile
SOURCES := compile.f $(wildcard hdl/*.sv) $(wildcard verification/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_top: $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module tb_top -f compile.f

run: obj_dir/Vtb_top
	obj_dir/Vtb_top | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
